// File: filelist.f
+incdir+source
+incdir+bench
source/csma_pkg.sv
source/cw_exp.sv
source/backoff_draw.sv
source/slot_timer.sv
source/backoff_counter.sv
source/csma_backoff_top.sv
bench/csma_backoff_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the backoff testbench with Verilator, run it, then grade the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ns --top-module csma_backoff_tb \
    -f filelist.f -o csma_backoff_sim > build.log 2>&1 \
    && ./obj_dir/csma_backoff_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^All tests passed$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: bench/csma_backoff_checks.svh
`ifndef CSMA_BACKOFF_CHECKS_SVH
`define CSMA_BACKOFF_CHECKS_SVH

task automatic check_cw(input cw_exp_t actual, input cw_exp_t expected, input string what);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("mismatch at %0t ns: %s, cw_exp %0d, expected %0d", $time, what, actual,
                 expected);
    end
endtask

// slot counts are checked against a range, lo == hi for an exact value
task automatic check_slots(input slot_count_t actual, input slot_count_t lo,
                           input slot_count_t hi, input string what);
    check_count++;
    if ((actual < lo) || (actual > hi)) begin
        error_count++;
        $display("mismatch at %0t ns: %s, slots %0d, expected %0d..%0d", $time, what, actual,
                 lo, hi);
    end
endtask

task automatic check_cycles(input int actual, input int lo, input int hi, input string what);
    check_count++;
    if ((actual < lo) || (actual > hi)) begin
        error_count++;
        $display("mismatch at %0t ns: %s, %0d cycles, expected %0d..%0d", $time, what, actual,
                 lo, hi);
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

// step to the drive point of the next cycle
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

// counts cycles from the draw until tx_grant, with optional extra request and busy burst
task automatic wait_grant(input bit extra_req, input int busy_start, input int busy_len,
                          output int cycles, output slot_count_t slots);
    int n;
    bit granted;
    n = 0;
    granted = 1'b0;
    slots = '0;
    while (!granted && (n < GRANT_TIMEOUT)) begin
        next_cycle();
        n++;
        if (n == 1) begin
            slots = backoff_slots; // loaded on the edge after the draw
        end
        granted = tx_grant;
        if (!granted) begin
            check_flag(backoff_active, 1'b1, "backoff_active during backoff");
        end
        tx_request  = extra_req && (n == 3); // must be ignored, backoff is running
        medium_busy = (busy_len > 0) && (n >= busy_start) && (n < busy_start + busy_len);
    end
    tx_request  = 1'b0;
    medium_busy = 1'b0;
    cycles = n;
    if (!granted) begin
        timed_out = 1'b1;
        error_count++;
        $display("timeout at %0t ns: tx_grant never came within %0d cycles after the draw",
                 $time, GRANT_TIMEOUT);
    end else begin
        check_flag(backoff_active, 1'b0, "backoff_active after grant");
    end
endtask

`endif

// File: bench/csma_backoff_tb.sv
`timescale 1ns/1ns
`include "csma_defs.svh"

module csma_backoff_tb;
    import csma_pkg::*;

    localparam int GRANT_TIMEOUT = 1000;
    localparam int DRAWS_PER_EXP = 8;

    logic                           clk = 1'b0;
    logic                           rstn;
    logic                           tx_request;
    logic                           medium_busy;
    logic                           retrans_trigger;
    logic                           tx_try_complete;
    logic                           quit_retrans;
    queue_idx_t                     tx_queue_idx;
    logic [`CSMA_NUM_QUEUES*8-1:0]  cw_combined;
    logic                           tx_grant;
    logic                           backoff_active;
    cw_exp_t                        cw_exp;
    slot_count_t                    backoff_slots;

    cw_exp_t     min_cfg [`CSMA_NUM_QUEUES];
    cw_exp_t     max_cfg [`CSMA_NUM_QUEUES];
    logic [31:0] rng_state;
    int          check_count = 0;
    int          error_count = 0;
    bit          timed_out = 1'b0;

    `include "csma_backoff_checks.svh"

    always #10 clk = ~clk;

    csma_backoff_top csma_backoff_top_inst (
        .clk             (clk),
        .rstn            (rstn),
        .tx_request      (tx_request),
        .medium_busy     (medium_busy),
        .retrans_trigger (retrans_trigger),
        .tx_try_complete (tx_try_complete),
        .quit_retrans    (quit_retrans),
        .tx_queue_idx    (tx_queue_idx),
        .cw_combined     (cw_combined),
        .tx_grant        (tx_grant),
        .backoff_active  (backoff_active),
        .cw_exp          (cw_exp),
        .backoff_slots   (backoff_slots)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one cycle pulse on any mix of the exponent events
    task automatic pulse_events(input logic retrans, input logic complete, input logic quit);
        retrans_trigger = retrans;
        tx_try_complete = complete;
        quit_retrans    = quit;
        next_cycle();
        retrans_trigger = 1'b0;
        tx_try_complete = 1'b0;
        quit_retrans    = 1'b0;
    endtask

    task automatic set_queue(input queue_idx_t q);
        tx_queue_idx = q;
        repeat (3) next_cycle(); // change seen after two edges
        check_cw(cw_exp, min_cfg[q], "minimum after queue change");
    endtask

    task automatic run_backoff(input bit extra_req, input int busy_start, input int busy_len,
                               output slot_count_t slots, output int cycles);
        slots = '0;
        cycles = 0;
        if (!timed_out) begin
            tx_request = 1'b1;
            next_cycle(); // draw result is out now
            tx_request = 1'b0;
            wait_grant(extra_req, busy_start, busy_len, cycles, slots);
        end
    endtask

    task automatic queue_change_sequence();
        check_cw(cw_exp, min_cfg[0], "queue 0 minimum after reset");
        set_queue(2'd3);
        set_queue(2'd1);
        set_queue(2'd0);
    endtask

    task automatic retrans_growth(input queue_idx_t q);
        cw_exp_t expected;
        int lo;
        int hi;
        set_queue(q);
        lo = int'(min_cfg[q]);
        hi = int'(max_cfg[q]);
        for (int k = 1; k <= hi - lo + 2; k++) begin
            pulse_events(1'b1, 1'b0, 1'b0);
            expected = (lo + k > hi) ? max_cfg[q] : cw_exp_t'(lo + k);
            check_cw(cw_exp, expected, "growth per retransmission");
        end
    endtask

    task automatic reset_events(input queue_idx_t q);
        set_queue(q);
        pulse_events(1'b1, 1'b0, 1'b0);
        pulse_events(1'b1, 1'b1, 1'b0); // completion beats growth
        check_cw(cw_exp, min_cfg[q], "minimum after tx_try_complete");
        pulse_events(1'b1, 1'b0, 1'b0);
        pulse_events(1'b1, 1'b0, 1'b1);
        check_cw(cw_exp, min_cfg[q], "minimum after quit_retrans");
    endtask

    task automatic draw_bound();
        slot_count_t slots;
        slot_count_t window;
        int cycles;
        set_queue(2'd1); // queue 1 starts at exponent 0
        for (int e = 0; e <= int'(max_cfg[1]); e++) begin
            check_cw(cw_exp, cw_exp_t'(e), "exponent before draws");
            window = slot_count_t'((32'd1 << e) - 32'd1);
            for (int r = 0; r < DRAWS_PER_EXP; r++) begin
                run_backoff(1'b0, 0, 0, slots, cycles);
                check_slots(slots, '0, window, "drawn slots within window");
            end
            pulse_events(1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic idle_grant_timing();
        slot_count_t slots;
        int cycles;
        int expected;
        set_queue(2'd0);
        for (int r = 0; r < 4; r++) begin
            run_backoff(1'b1, 0, 0, slots, cycles);
            expected = (int'(slots) + 1) * `CSMA_SLOT_CYCLES;
            if (!timed_out) begin
                check_cycles(cycles, expected, expected, "idle grant delay");
                check_slots(backoff_slots, slots, slots, "slots after second request");
            end
            if (r == 1) begin
                pulse_events(1'b1, 1'b0, 1'b0); // window 3 grows to 7
            end
        end
    endtask

    task automatic busy_freeze();
        slot_count_t slots;
        int cycles;
        int base;
        int busy_len;
        for (int r = 0; r < 3; r++) begin
            busy_len = 5 + 7 * r;
            run_backoff(1'b0, 4, busy_len, slots, cycles);
            base = (int'(slots) + 1) * `CSMA_SLOT_CYCLES;
            if (!timed_out) begin
                check_cycles(cycles - base, busy_len, busy_len + `CSMA_SLOT_CYCLES,
                             "grant delay from busy burst");
            end
        end
    endtask

    initial begin
        int lo;
        int hi;
        rstn            = 1'b0;
        tx_request      = 1'b0;
        medium_busy     = 1'b0;
        retrans_trigger = 1'b0;
        tx_try_complete = 1'b0;
        quit_retrans    = 1'b0;
        tx_queue_idx    = '0;
        min_cfg[0] = 4'd2; // short windows for timing
        max_cfg[0] = 4'd3;
        min_cfg[1] = 4'd0; // full draw range 0..4
        max_cfg[1] = 4'd4;
        rng_state = 32'h997b;
        for (int q = 2; q < `CSMA_NUM_QUEUES; q++) begin
            rng_state = xorshift32(rng_state);
            lo = 3 * q - 1 + int'(rng_state % 32'd3);
            rng_state = xorshift32(rng_state);
            hi = lo + int'(rng_state % 32'(16 - lo));
            min_cfg[q] = cw_exp_t'(lo);
            max_cfg[q] = cw_exp_t'(hi);
        end
        cw_combined = '0;
        for (int q = 0; q < `CSMA_NUM_QUEUES; q++) begin
            cw_combined[8*q +: 4]   = min_cfg[q];
            cw_combined[8*q+4 +: 4] = max_cfg[q];
        end
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;

        queue_change_sequence();
        retrans_growth(2'd2);
        reset_events(2'd0);
        draw_bound();
        idle_grant_timing();
        busy_freeze();

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/csma_backoff_top.sv
`timescale 1ns/1ns
`include "csma_defs.svh"

module csma_backoff_top (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           tx_request,
    input  logic                           medium_busy,
    input  logic                           retrans_trigger,
    input  logic                           tx_try_complete,
    input  logic                           quit_retrans,
    input  csma_pkg::queue_idx_t           tx_queue_idx,
    input  logic [`CSMA_NUM_QUEUES*8-1:0]  cw_combined,
    output logic                           tx_grant,
    output logic                           backoff_active,
    output csma_pkg::cw_exp_t              cw_exp,
    output csma_pkg::slot_count_t          backoff_slots
);
    import csma_pkg::*;

    logic        draw_req;
    logic        draw_valid;
    slot_count_t draw_slots;
    logic        slot_tick;

    // a request during a running backoff is dropped
    assign draw_req = tx_request && !backoff_active;

    cw_exp cw_exp_inst (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .quit_retrans    (quit_retrans),
        .retrans_trigger (retrans_trigger),
        .cw_combined     (cw_combined),
        .tx_queue_idx    (tx_queue_idx),
        .cw_exp          (cw_exp)
    );

    backoff_draw backoff_draw_inst (
        .clk        (clk),
        .rstn       (rstn),
        .draw_req   (draw_req),
        .cw_exp     (cw_exp),
        .draw_valid (draw_valid),
        .draw_slots (draw_slots)
    );

    slot_timer slot_timer_inst (
        .clk         (clk),
        .rstn        (rstn),
        .medium_busy (medium_busy),
        .restart     (draw_valid), // slots are timed from the draw
        .slot_tick   (slot_tick)
    );

    backoff_counter backoff_counter_inst (
        .clk            (clk),
        .rstn           (rstn),
        .load           (draw_valid),
        .slot_tick      (slot_tick),
        .load_slots     (draw_slots),
        .backoff_active (backoff_active),
        .tx_grant       (tx_grant),
        .backoff_slots  (backoff_slots)
    );

endmodule

// File: source/backoff_counter.sv
`timescale 1ns/1ns

module backoff_counter (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load,
    input  logic                   slot_tick,
    input  csma_pkg::slot_count_t  load_slots,
    output logic                   backoff_active,
    output logic                   tx_grant,
    output csma_pkg::slot_count_t  backoff_slots
);
    import csma_pkg::*;

    slot_count_t remaining; // slots left before the grant tick
    logic        count_zero;
    logic        grant_now;

    assign count_zero = (remaining == '0);
    assign grant_now  = backoff_active && slot_tick && count_zero;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            remaining      <= '0;
            backoff_active <= 1'b0;
            tx_grant       <= 1'b0;
        end else begin
            tx_grant <= grant_now; // single cycle pulse
            if (load) begin
                remaining      <= load_slots;
                backoff_active <= 1'b1;
            end else if (grant_now) begin
                backoff_active <= 1'b0; // done, medium is ours
            end else if (backoff_active && slot_tick) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // last drawn count, kept for the MAC logs
    always_ff @(posedge clk) begin
        if (load) begin
            backoff_slots <= load_slots;
        end
    end

endmodule

// File: source/slot_timer.sv
`timescale 1ns/1ns
`include "csma_defs.svh"

module slot_timer (
    input  logic clk,
    input  logic rstn,
    input  logic medium_busy,
    input  logic restart,
    output logic slot_tick
);

    localparam logic [`CSMA_SLOT_CNT_W-1:0] LAST_IDLE =
        `CSMA_SLOT_CNT_W'(`CSMA_SLOT_CYCLES - 1);

    logic [`CSMA_SLOT_CNT_W-1:0] idle_cnt; // idle cycles already seen in this slot

    // tick in the last idle cycle of a slot
    assign slot_tick = !medium_busy && !restart && (idle_cnt == LAST_IDLE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            idle_cnt <= '0;
        end else if (medium_busy) begin
            idle_cnt <= '0; // partial slot is lost
        end else if (restart) begin
            // restart cycle is the first idle cycle of a fresh slot
            idle_cnt <= `CSMA_SLOT_CNT_W'(1);
        end else if (slot_tick) begin
            idle_cnt <= '0; // wrap
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

endmodule

// File: source/backoff_draw.sv
`timescale 1ns/1ns
`include "csma_defs.svh"

module backoff_draw (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   draw_req,
    input  csma_pkg::cw_exp_t      cw_exp,
    output logic                   draw_valid,
    output csma_pkg::slot_count_t  draw_slots
);
    import csma_pkg::*;

    logic [15:0] rng_q;
    logic [15:0] rng_a;
    logic [15:0] rng_b;
    logic [15:0] rng_next;

    // 16-bit xorshift with shifts 7, 9, 8
    always_comb begin
        rng_a    = rng_q ^ (rng_q << 7);
        rng_b    = rng_a ^ (rng_a >> 9);
        rng_next = rng_b ^ (rng_b << 8);
    end

    // generator runs every cycle so draws depend on request timing
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rng_q      <= `CSMA_RAND_SEED;
            draw_valid <= 1'b0;
        end else begin
            rng_q      <= rng_next;
            draw_valid <= draw_req; // one cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        if (draw_req) begin
            draw_slots <= rng_q & cw_window(cw_exp); // bound by current window
        end
    end

endmodule

// File: source/cw_exp.sv
`timescale 1ns/1ns
`include "csma_defs.svh"

module cw_exp (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           tx_try_complete,
    input  logic                           quit_retrans,
    input  logic                           retrans_trigger,
    input  logic [`CSMA_NUM_QUEUES*8-1:0]  cw_combined,
    input  csma_pkg::queue_idx_t           tx_queue_idx,
    output csma_pkg::cw_exp_t              cw_exp
);
    import csma_pkg::*;

    localparam int QUEUE_FIELD_W = 8; // min in low nibble, max in high nibble

    cw_exp_t    q0_min;
    cw_exp_t    cw_min;
    cw_exp_t    cw_max;
    queue_idx_t queue_idx_q;
    logic       cw_update;

    assign q0_min = cw_combined[$bits(cw_exp_t)-1:0]; // reset value, queue 0 minimum

    // limits of the queue currently selected by the MAC
    always_comb begin
        cw_min = cw_combined[QUEUE_FIELD_W*tx_queue_idx +: $bits(cw_exp_t)];
        cw_max = cw_combined[QUEUE_FIELD_W*tx_queue_idx + $bits(cw_exp_t) +: $bits(cw_exp_t)];
    end

    // a queue change shows up one edge later as cw_update
    always_ff @(posedge clk) begin
        if (!rstn) begin
            queue_idx_q <= '0;
            cw_update   <= 1'b0;
        end else begin
            queue_idx_q <= tx_queue_idx;
            cw_update   <= (queue_idx_q != tx_queue_idx);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cw_exp <= q0_min;
        end else if (cw_update || tx_try_complete || quit_retrans) begin
            cw_exp <= cw_min; // reset events win over growth
        end else if (retrans_trigger && (cw_exp < cw_max)) begin
            cw_exp <= cw_exp + 1'b1; // grow, saturating at the queue maximum
        end
    end

endmodule

// File: source/csma_pkg.sv
package csma_pkg;

    // window exponent, window is (2**exp) - 1 slots
    typedef logic [3:0] cw_exp_t;

    // transmit queue number
    typedef logic [1:0] queue_idx_t;

    // backoff slot count, wide enough for exponent 15
    typedef logic [15:0] slot_count_t;

    // mask of the contention window for a given exponent
    function automatic slot_count_t cw_window(cw_exp_t exp_val);
        slot_count_t one_hot;
        one_hot = slot_count_t'(1) << exp_val; // 2**exp, still fits for exp 15
        return one_hot - slot_count_t'(1);
    endfunction

endpackage

// File: source/csma_defs.svh
`ifndef CSMA_DEFS_SVH
`define CSMA_DEFS_SVH

// transmit queues, each owns one byte of the configuration word
`define CSMA_NUM_QUEUES 4

// idle clock cycles that make up one backoff slot
`define CSMA_SLOT_CYCLES 9

// reset state of the slot draw generator, must be nonzero
`define CSMA_RAND_SEED 16'hace1

// slot timer counter width, holds CSMA_SLOT_CYCLES - 1
`define CSMA_SLOT_CNT_W 8

`endif
